//--- conv_acc_pkg.sv
package conv_acc_pkg;

  // One word on every memory bus
  typedef logic [31:0] word_t;

  // Word address into any of the memories
  typedef logic [7:0] addr_t;

  // Pixel or weight, sign-extended in the low byte of a word
  typedef logic signed [7:0] pixel_t;

  // Accumulator, bias and written result
  typedef logic signed [31:0] acc_t;

  // Operation selected by mode_i
  typedef enum logic [3:0] {
    MODE_IDLE     = 4'd0,
    MODE_CONV_1X1 = 4'd1,
    MODE_CONV_3X3 = 4'd2,
    MODE_MAX_POOL = 4'd3
  } mode_e;

  // Side of the square input feature map
  localparam int MAP_DIM = 6;

  // Side of the convolution kernel
  localparam int K_DIM = 3;

  // Side of the pooled map, 2x2 blocks at stride 2
  localparam int POOL_DIM = MAP_DIM / 2;

endpackage

//--- sp_ram_intf.sv
`timescale 1ns/1ps

interface sp_ram_intf
  import conv_acc_pkg::*;
();

  logic  cs;
  logic  we;
  addr_t addr;
  word_t wdata;
  // Valid the cycle after a read select
  word_t rdata;

  modport compute (
    output cs,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport memory (
    input  cs,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- conv_bus_switcher.sv
`timescale 1ns/1ps

module conv_bus_switcher
  import conv_acc_pkg::*;
(
  input  mode_e              mode_i,
  // Unit side
  sp_ram_intf.memory         c1_bias_i,
  sp_ram_intf.memory         c1_input_i,
  sp_ram_intf.memory         c1_output_i,
  sp_ram_intf.memory         c3_bias_i,
  sp_ram_intf.memory         c3_weight_i,
  sp_ram_intf.memory         c3_input_i,
  sp_ram_intf.memory         c3_output_i,
  sp_ram_intf.memory         mp_input_i,
  sp_ram_intf.memory         mp_output_i,
  // External memories
  sp_ram_intf.compute        bias_o,
  sp_ram_intf.compute        weight_o,
  sp_ram_intf.compute        input_o,
  sp_ram_intf.compute        output_o
);

  // Read data goes back to every unit
  assign c1_bias_i.rdata   = bias_o.rdata;
  assign c1_input_i.rdata  = input_o.rdata;
  assign c1_output_i.rdata = output_o.rdata;
  assign c3_bias_i.rdata   = bias_o.rdata;
  assign c3_weight_i.rdata = weight_o.rdata;
  assign c3_input_i.rdata  = input_o.rdata;
  assign c3_output_i.rdata = output_o.rdata;
  assign mp_input_i.rdata  = input_o.rdata;
  assign mp_output_i.rdata = output_o.rdata;

  always_comb begin
    // Anything not routed below stays deselected
    {bias_o.cs, bias_o.we, bias_o.addr, bias_o.wdata}         = '0;
    {weight_o.cs, weight_o.we, weight_o.addr, weight_o.wdata} = '0;
    {input_o.cs, input_o.we, input_o.addr, input_o.wdata}     = '0;
    {output_o.cs, output_o.we, output_o.addr, output_o.wdata} = '0;
    case (mode_i)
      MODE_CONV_1X1: begin
        {bias_o.cs, bias_o.we, bias_o.addr, bias_o.wdata} =
          {c1_bias_i.cs, c1_bias_i.we, c1_bias_i.addr, c1_bias_i.wdata};
        {input_o.cs, input_o.we, input_o.addr, input_o.wdata} =
          {c1_input_i.cs, c1_input_i.we, c1_input_i.addr, c1_input_i.wdata};
        {output_o.cs, output_o.we, output_o.addr, output_o.wdata} =
          {c1_output_i.cs, c1_output_i.we, c1_output_i.addr, c1_output_i.wdata};
      end
      MODE_CONV_3X3: begin
        {bias_o.cs, bias_o.we, bias_o.addr, bias_o.wdata} =
          {c3_bias_i.cs, c3_bias_i.we, c3_bias_i.addr, c3_bias_i.wdata};
        {weight_o.cs, weight_o.we, weight_o.addr, weight_o.wdata} =
          {c3_weight_i.cs, c3_weight_i.we, c3_weight_i.addr, c3_weight_i.wdata};
        {input_o.cs, input_o.we, input_o.addr, input_o.wdata} =
          {c3_input_i.cs, c3_input_i.we, c3_input_i.addr, c3_input_i.wdata};
        {output_o.cs, output_o.we, output_o.addr, output_o.wdata} =
          {c3_output_i.cs, c3_output_i.we, c3_output_i.addr, c3_output_i.wdata};
      end
      MODE_MAX_POOL: begin
        // No bias or weight access when pooling
        {input_o.cs, input_o.we, input_o.addr, input_o.wdata} =
          {mp_input_i.cs, mp_input_i.we, mp_input_i.addr, mp_input_i.wdata};
        {output_o.cs, output_o.we, output_o.addr, output_o.wdata} =
          {mp_output_i.cs, mp_output_i.we, mp_output_i.addr, mp_output_i.wdata};
      end
      default: begin
      end
    endcase
  end

endmodule

//--- conv_1x1.sv
`timescale 1ns/1ps

module conv_1x1
  import conv_acc_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        start_i,
  input  word_t       w8_i,
  output logic        finish_o,
  sp_ram_intf.compute bias_i,
  sp_ram_intf.compute input_i,
  sp_ram_intf.compute output_i
);

  typedef enum logic [2:0] {IDLE, BIAS, READ, WRITE, DONE} state_e;

  state_e state;
  // Second cycle of a read, data is on rdata
  logic   phase;
  addr_t  pix_cnt;
  acc_t   bias_q;
  pixel_t pix_q;
  acc_t   result;

  assign result = bias_q + acc_t'(pix_q) * acc_t'(pixel_t'(w8_i[7:0]));

  // Bias always sits at word 0
  assign bias_i.cs    = (state == BIAS) && !phase;
  assign bias_i.we    = 1'b0;
  assign bias_i.addr  = '0;
  assign bias_i.wdata = '0;

  assign input_i.cs    = (state == READ) && !phase;
  assign input_i.we    = 1'b0;
  assign input_i.addr  = pix_cnt;
  assign input_i.wdata = '0;

  assign output_i.cs    = (state == WRITE);
  assign output_i.we    = (state == WRITE);
  assign output_i.addr  = pix_cnt;
  assign output_i.wdata = word_t'(result);

  assign finish_o = (state == DONE);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= IDLE;
      phase   <= 1'b0;
      pix_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            state   <= BIAS;
            phase   <= 1'b0;
            pix_cnt <= '0;
          end
        end
        BIAS: begin
          phase <= !phase;
          if (phase) state <= READ;
        end
        READ: begin
          phase <= !phase;
          if (phase) state <= WRITE;
        end
        WRITE: begin
          if (pix_cnt == addr_t'(MAP_DIM * MAP_DIM - 1)) begin
            state <= DONE;
          end else begin
            pix_cnt <= pix_cnt + 1'b1;
            state   <= READ;
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Capture read data on the wait cycle
  always_ff @(posedge clk) begin
    if (state == BIAS && phase) bias_q <= acc_t'(bias_i.rdata);
    if (state == READ && phase) pix_q <= pixel_t'(input_i.rdata[7:0]);
  end

endmodule

//--- conv_3x3.sv
`timescale 1ns/1ps

module conv_3x3
  import conv_acc_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        start_i,
  output logic        finish_o,
  sp_ram_intf.compute bias_i,
  sp_ram_intf.compute weight_i,
  sp_ram_intf.compute input_i,
  sp_ram_intf.compute output_i
);

  typedef enum logic [2:0] {IDLE, LOAD, CONV, WRITE, DONE} state_e;

  state_e     state;
  // Load step 0 reads bias, 1..9 read the kernel, 10 drains
  logic [3:0] ld_cnt;
  logic [3:0] tap;
  logic [1:0] ki;
  logic [1:0] kj;
  logic [2:0] row;
  logic [2:0] col;
  acc_t       bias_q;
  acc_t       acc_q;
  acc_t       prod;
  pixel_t     kernel [K_DIM * K_DIM];

  assign bias_i.cs    = (state == LOAD) && (ld_cnt == 4'd0);
  assign bias_i.we    = 1'b0;
  assign bias_i.addr  = '0;
  assign bias_i.wdata = '0;

  assign weight_i.cs    = (state == LOAD) && (ld_cnt != 4'd0) &&
                          (ld_cnt <= 4'(K_DIM * K_DIM));
  assign weight_i.we    = 1'b0;
  assign weight_i.addr  = addr_t'(ld_cnt - 4'd1);
  assign weight_i.wdata = '0;

  // One tap read per cycle, window anchored at (row, col)
  assign input_i.cs    = (state == CONV) && (tap < 4'(K_DIM * K_DIM));
  assign input_i.we    = 1'b0;
  assign input_i.addr  = addr_t'((row + ki) * MAP_DIM + col + kj);
  assign input_i.wdata = '0;

  assign output_i.cs    = (state == WRITE);
  assign output_i.we    = (state == WRITE);
  assign output_i.addr  = addr_t'(row * (MAP_DIM - K_DIM + 1) + col);
  assign output_i.wdata = word_t'(acc_q);

  assign finish_o = (state == DONE);

  // Data returning now belongs to the previous tap
  assign prod = acc_t'(pixel_t'(input_i.rdata[7:0])) * acc_t'(kernel[tap - 4'd1]);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state  <= IDLE;
      ld_cnt <= '0;
      tap    <= '0;
      ki     <= '0;
      kj     <= '0;
      row    <= '0;
      col    <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            state  <= LOAD;
            ld_cnt <= '0;
            row    <= '0;
            col    <= '0;
          end
        end
        LOAD: begin
          ld_cnt <= ld_cnt + 1'b1;
          if (ld_cnt == 4'(K_DIM * K_DIM + 1)) begin
            state <= CONV;
            tap   <= '0;
            ki    <= '0;
            kj    <= '0;
          end
        end
        CONV: begin
          tap <= tap + 1'b1;
          if (kj == 2'(K_DIM - 1)) begin
            kj <= '0;
            ki <= ki + 1'b1;
          end else begin
            kj <= kj + 1'b1;
          end
          if (tap == 4'(K_DIM * K_DIM)) state <= WRITE;
        end
        WRITE: begin
          tap   <= '0;
          ki    <= '0;
          kj    <= '0;
          state <= CONV;
          if (col == 3'(MAP_DIM - K_DIM)) begin
            col <= '0;
            if (row == 3'(MAP_DIM - K_DIM)) state <= DONE;
            else row <= row + 1'b1;
          end else begin
            col <= col + 1'b1;
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LOAD && ld_cnt == 4'd1) bias_q <= acc_t'(bias_i.rdata);
    if (state == LOAD && ld_cnt >= 4'd2) begin
      kernel[ld_cnt - 4'd2] <= pixel_t'(weight_i.rdata[7:0]);
    end
    // First product of a window starts from the bias
    if (state == CONV && tap != 4'd0) acc_q <= ((tap == 4'd1) ? bias_q : acc_q) + prod;
  end

endmodule

//--- max_pool.sv
`timescale 1ns/1ps

module max_pool
  import conv_acc_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        start_i,
  output logic        finish_o,
  sp_ram_intf.compute input_i,
  sp_ram_intf.compute output_i
);

  typedef enum logic [1:0] {IDLE, READ, WRITE, DONE} state_e;

  state_e     state;
  // Taps 0..3 issue reads, data lags by one
  logic [2:0] tap;
  logic [1:0] row;
  logic [1:0] col;
  acc_t       pix;
  acc_t       max_q;

  assign pix = acc_t'(pixel_t'(input_i.rdata[7:0]));

  // tap[1] picks the block row, tap[0] the block column
  assign input_i.cs    = (state == READ) && !tap[2];
  assign input_i.we    = 1'b0;
  assign input_i.addr  = addr_t'((2 * row + tap[1]) * MAP_DIM + 2 * col + tap[0]);
  assign input_i.wdata = '0;

  assign output_i.cs    = (state == WRITE);
  assign output_i.we    = (state == WRITE);
  assign output_i.addr  = addr_t'(row * POOL_DIM + col);
  assign output_i.wdata = word_t'(max_q);

  assign finish_o = (state == DONE);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= IDLE;
      tap   <= '0;
      row   <= '0;
      col   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            state <= READ;
            tap   <= '0;
            row   <= '0;
            col   <= '0;
          end
        end
        READ: begin
          tap <= tap + 1'b1;
          if (tap == 3'd4) state <= WRITE;
        end
        WRITE: begin
          tap   <= '0;
          state <= READ;
          if (col == 2'(POOL_DIM - 1)) begin
            col <= '0;
            if (row == 2'(POOL_DIM - 1)) state <= DONE;
            else row <= row + 1'b1;
          end else begin
            col <= col + 1'b1;
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Running signed maximum over the block
  always_ff @(posedge clk) begin
    if (state == READ && tap != 3'd0) begin
      if (tap == 3'd1 || pix > max_q) max_q <= pix;
    end
  end

endmodule

//--- conv_acc.sv
`timescale 1ns/1ps

module conv_acc
  import conv_acc_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       start_i,
  input  logic [3:0] mode_i,
  input  word_t      w8_i,
  output logic       finish_o,
  // Bias memory, bias at word 0
  output logic       bias_cs_o,
  input  word_t      bias_rdata_i,
  // Weight memory
  output logic       weight_cs_o,
  output addr_t      weight_addr_o,
  input  word_t      weight_rdata_i,
  // Input feature map
  output logic       in_cs_o,
  output addr_t      in_addr_o,
  input  word_t      in_rdata_i,
  // Output memory, write only
  output logic       out_cs_o,
  output addr_t      out_addr_o,
  output word_t      out_wdata_o
);

  mode_e mode;
  logic  start_c1;
  logic  start_c3;
  logic  start_mp;
  logic  finish_c1;
  logic  finish_c3;
  logic  finish_mp;

  sp_ram_intf c1_bias_bus ();
  sp_ram_intf c1_input_bus ();
  sp_ram_intf c1_output_bus ();
  sp_ram_intf c3_bias_bus ();
  sp_ram_intf c3_weight_bus ();
  sp_ram_intf c3_input_bus ();
  sp_ram_intf c3_output_bus ();
  sp_ram_intf mp_input_bus ();
  sp_ram_intf mp_output_bus ();

  // External side
  sp_ram_intf bias_bus ();
  sp_ram_intf weight_bus ();
  sp_ram_intf input_bus ();
  sp_ram_intf output_bus ();

  assign mode = mode_e'(mode_i);

  // Steer start to the selected unit and take its finish back
  always_comb begin
    start_c1 = 1'b0;
    start_c3 = 1'b0;
    start_mp = 1'b0;
    finish_o = 1'b0;
    case (mode)
      MODE_CONV_1X1: begin
        start_c1 = start_i;
        finish_o = finish_c1;
      end
      MODE_CONV_3X3: begin
        start_c3 = start_i;
        finish_o = finish_c3;
      end
      MODE_MAX_POOL: begin
        start_mp = start_i;
        finish_o = finish_mp;
      end
      default: begin
      end
    endcase
  end

  conv_bus_switcher u_switcher (
    .mode_i      (mode),
    .c1_bias_i   (c1_bias_bus),
    .c1_input_i  (c1_input_bus),
    .c1_output_i (c1_output_bus),
    .c3_bias_i   (c3_bias_bus),
    .c3_weight_i (c3_weight_bus),
    .c3_input_i  (c3_input_bus),
    .c3_output_i (c3_output_bus),
    .mp_input_i  (mp_input_bus),
    .mp_output_i (mp_output_bus),
    .bias_o      (bias_bus),
    .weight_o    (weight_bus),
    .input_o     (input_bus),
    .output_o    (output_bus)
  );

  conv_1x1 u_conv_1x1 (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (start_c1),
    .w8_i     (w8_i),
    .finish_o (finish_c1),
    .bias_i   (c1_bias_bus),
    .input_i  (c1_input_bus),
    .output_i (c1_output_bus)
  );

  conv_3x3 u_conv_3x3 (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (start_c3),
    .finish_o (finish_c3),
    .bias_i   (c3_bias_bus),
    .weight_i (c3_weight_bus),
    .input_i  (c3_input_bus),
    .output_i (c3_output_bus)
  );

  max_pool u_max_pool (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (start_mp),
    .finish_o (finish_mp),
    .input_i  (mp_input_bus),
    .output_i (mp_output_bus)
  );

  // Flatten external buses to memory ports
  assign bias_cs_o      = bias_bus.cs;
  assign bias_bus.rdata = bias_rdata_i;

  assign weight_cs_o      = weight_bus.cs;
  assign weight_addr_o    = weight_bus.addr;
  assign weight_bus.rdata = weight_rdata_i;

  assign in_cs_o         = input_bus.cs;
  assign in_addr_o       = input_bus.addr;
  assign input_bus.rdata = in_rdata_i;

  // Output memory is never read, its cs implies write
  assign out_cs_o         = output_bus.cs;
  assign out_addr_o       = output_bus.addr;
  assign out_wdata_o      = output_bus.wdata;
  assign output_bus.rdata = '0;

endmodule

//--- conv_acc_properties.sv
`timescale 1ns/1ps

module conv_acc_properties
  import conv_acc_pkg::*;
(
  input logic       clk,
  input logic       reset_i,
  input logic [3:0] mode_i,
  input logic       finish_o,
  input logic       bias_cs_o,
  input logic       weight_cs_o,
  input logic       in_cs_o,
  input logic       out_cs_o
);

  int fail_cnt = 0;

  // Finish is a single-cycle strobe
  finish_single: assert property (
    @(posedge clk) disable iff (reset_i) finish_o |=> !finish_o
  ) else begin
    fail_cnt++;
    $error("finish_o high on two consecutive cycles");
  end

  // Every unit is idle once reset has been taken
  quiet_after_reset: assert property (
    @(posedge clk) reset_i |=> !(bias_cs_o || weight_cs_o || in_cs_o || out_cs_o)
  ) else begin
    fail_cnt++;
    $error("memory select high in the cycle after reset");
  end

  idle_no_write: assert property (
    @(posedge clk) disable iff (reset_i) !(out_cs_o && mode_i == MODE_IDLE)
  ) else begin
    fail_cnt++;
    $error("output write while mode_i is idle");
  end

endmodule

//--- conv_acc_tb.sv
`timescale 1ns/1ps

module conv_acc_tb
  import conv_acc_pkg::*;
();

  // All runs together take about a thousand cycles
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int NPIX = MAP_DIM * MAP_DIM;
  localparam int VALID_DIM = MAP_DIM - 2;
  localparam int POOL_SIDE = MAP_DIM / 2;

  logic       clk;
  logic       reset_i;
  logic       start_i;
  logic [3:0] mode_i;
  word_t      w8_i;
  logic       finish_o;
  logic       bias_cs_o;
  logic       weight_cs_o;
  addr_t      weight_addr_o;
  logic       in_cs_o;
  addr_t      in_addr_o;
  logic       out_cs_o;
  addr_t      out_addr_o;
  word_t      out_wdata_o;
  word_t      bias_rdata = '0;
  word_t      weight_rdata = '0;
  word_t      in_rdata = '0;
  logic       clear_out = 1'b0;

  word_t bias_mem;
  word_t weight_mem [256];
  word_t in_mem [256];
  word_t out_mem [256];

  // Reference copies of the loaded data
  int pix [NPIX];
  int kern [9];
  int bias_val;
  int cycle_cnt;

  conv_acc dut0 (
    .clk            (clk),
    .reset_i        (reset_i),
    .start_i        (start_i),
    .mode_i         (mode_i),
    .w8_i           (w8_i),
    .finish_o       (finish_o),
    .bias_cs_o      (bias_cs_o),
    .bias_rdata_i   (bias_rdata),
    .weight_cs_o    (weight_cs_o),
    .weight_addr_o  (weight_addr_o),
    .weight_rdata_i (weight_rdata),
    .in_cs_o        (in_cs_o),
    .in_addr_o      (in_addr_o),
    .in_rdata_i     (in_rdata),
    .out_cs_o       (out_cs_o),
    .out_addr_o     (out_addr_o),
    .out_wdata_o    (out_wdata_o)
  );

  bind conv_acc conv_acc_properties u_props (
    .clk         (clk),
    .reset_i     (reset_i),
    .mode_i      (mode_i),
    .finish_o    (finish_o),
    .bias_cs_o   (bias_cs_o),
    .weight_cs_o (weight_cs_o),
    .in_cs_o     (in_cs_o),
    .out_cs_o    (out_cs_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: run still going after %0d cycles, a unit never finished",
             TIMEOUT_CYCLES);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

  // Bound checker flagged a protocol violation
  initial begin
    wait (dut0.u_props.fail_cnt != 0);
    $display("ERROR: a concurrent assertion on the DUT strobes failed");
    $display("Verification failed");
    $fatal(1, "assertion failure");
  end

  // Memories with a one-cycle registered read
  always @(posedge clk) begin
    if (bias_cs_o) bias_rdata <= bias_mem;
    if (weight_cs_o) weight_rdata <= weight_mem[weight_addr_o];
    if (in_cs_o) in_rdata <= in_mem[in_addr_o];
    if (clear_out) begin
      for (int a = 0; a < 256; a++) begin
        out_mem[a] <= word_t'(32'hdead_0000 + a);
      end
    end else if (out_cs_o) begin
      out_mem[out_addr_o] <= out_wdata_o;
    end
  end

  task automatic check_value(input string name, input int observed, input int expected);
    if (observed !== expected) begin
      $display("MISMATCH at %0t: %s observed %0d expected %0d",
               $time, name, observed, expected);
      $display("Verification failed");
      $fatal(1, "check of %s", name);
    end
  endtask

  task automatic set_pixel(input int idx, input int value);
    pix[idx] = value;
    in_mem[idx] = word_t'(value);
  endtask

  task automatic load_data();
    logic signed [7:0] b;
    for (int i = 0; i < NPIX; i++) begin
      b = 8'($urandom);
      set_pixel(i, b);
    end
    for (int i = 0; i < 9; i++) begin
      b = 8'($urandom);
      kern[i] = b;
      weight_mem[i] = word_t'(kern[i]);
    end
    bias_val = int'($urandom);
    bias_mem = word_t'(bias_val);
  endtask

  task automatic clear_output();
    @(posedge clk);
    clear_out <= 1'b1;
    @(posedge clk);
    clear_out <= 1'b0;
  endtask

  // Start one operation and follow it to its finish strobe
  task automatic run_op(input logic [3:0] mode, input word_t w8,
                        output int writes, output int side_sel);
    int fin;
    writes = 0;
    side_sel = 0;
    fin = 0;
    @(posedge clk);
    mode_i  <= mode;
    w8_i    <= w8;
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    while (fin == 0) begin
      @(negedge clk);
      if (out_cs_o) writes++;
      if (bias_cs_o || weight_cs_o) side_sel++;
      if (finish_o) fin = 1;
    end
    repeat (2) begin
      @(negedge clk);
      if (finish_o) fin++;
    end
    check_value("finish_o pulse count", fin, 1);
  endtask

  function automatic int expect_3x3(input int r, input int c);
    int sum;
    sum = bias_val;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        sum += pix[(r + i) * MAP_DIM + c + j] * kern[i * 3 + j];
      end
    end
    return sum;
  endfunction

  function automatic int expect_pool(input int r, input int c);
    int best;
    int base;
    base = 2 * r * MAP_DIM + 2 * c;
    best = pix[base];
    if (pix[base + 1] > best) best = pix[base + 1];
    if (pix[base + MAP_DIM] > best) best = pix[base + MAP_DIM];
    if (pix[base + MAP_DIM + 1] > best) best = pix[base + MAP_DIM + 1];
    return best;
  endfunction

  task automatic test_conv_1x1();
    int writes;
    int side;
    int w;
    word_t w8;
    logic signed [7:0] wb;
    load_data();
    w8 = $urandom;
    wb = w8[7:0];
    w = wb;
    clear_output();
    run_op(MODE_CONV_1X1, w8, writes, side);
    check_value("1x1 output writes", writes, NPIX);
    // Single bias read, weight bus stays quiet
    check_value("1x1 bias/weight selects", side, 1);
    for (int i = 0; i < NPIX; i++) begin
      check_value($sformatf("out_mem[%0d]", i), int'(out_mem[i]), bias_val + pix[i] * w);
    end
  endtask

  task automatic test_conv_3x3();
    int writes;
    int side;
    load_data();
    clear_output();
    // w8_i is random here, the 3x3 rule ignores it
    run_op(MODE_CONV_3X3, $urandom, writes, side);
    check_value("3x3 output writes", writes, VALID_DIM * VALID_DIM);
    // One bias read and nine kernel reads
    check_value("3x3 bias/weight selects", side, 1 + 9);
    for (int r = 0; r < VALID_DIM; r++) begin
      for (int c = 0; c < VALID_DIM; c++) begin
        check_value($sformatf("out_mem[%0d]", r * VALID_DIM + c),
                    int'(out_mem[r * VALID_DIM + c]), expect_3x3(r, c));
      end
    end
  endtask

  task automatic test_max_pool();
    int writes;
    int side;
    load_data();
    // Block (1,1) gets an all-negative maximum
    set_pixel(14, -1 - int'($urandom % 100));
    set_pixel(15, -1 - int'($urandom % 100));
    set_pixel(20, -1 - int'($urandom % 100));
    set_pixel(21, -1 - int'($urandom % 100));
    clear_output();
    run_op(MODE_MAX_POOL, '0, writes, side);
    check_value("pool output writes", writes, POOL_SIDE * POOL_SIDE);
    check_value("pool bias/weight selects", side, 0);
    for (int r = 0; r < POOL_SIDE; r++) begin
      for (int c = 0; c < POOL_SIDE; c++) begin
        check_value($sformatf("out_mem[%0d]", r * POOL_SIDE + c),
                    int'(out_mem[r * POOL_SIDE + c]), expect_pool(r, c));
      end
    end
  endtask

  task automatic test_idle();
    int busy;
    busy = 0;
    @(posedge clk);
    mode_i  <= MODE_IDLE;
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    repeat (200) begin
      @(negedge clk);
      if (bias_cs_o || weight_cs_o || in_cs_o || out_cs_o || finish_o) busy++;
    end
    check_value("idle mode activity cycles", busy, 0);
  endtask

  task automatic test_reset_recovery();
    int sel;
    load_data();
    @(posedge clk);
    mode_i  <= MODE_CONV_3X3;
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    // Reset lands in the middle of the convolution
    repeat (60) @(posedge clk);
    reset_i <= 1'b1;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    sel = int'({bias_cs_o, weight_cs_o, in_cs_o, out_cs_o, finish_o});
    check_value("selects and finish after reset", sel, 0);
    test_conv_1x1();
  endtask

  initial begin
    void'($urandom(32'h4b64));
    reset_i = 1'b1;
    start_i = 1'b0;
    mode_i  = MODE_IDLE;
    w8_i    = '0;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    test_conv_1x1();
    test_conv_3x3();
    test_max_pool();
    test_idle();
    test_reset_recovery();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- vlog.f
conv_acc_pkg.sv
sp_ram_intf.sv
conv_bus_switcher.sv
conv_1x1.sv
conv_3x3.sv
max_pool.sv
conv_acc.sv
conv_acc_properties.sv
conv_acc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the run from its log
rm -f sim.log
verilator --binary --timing --assert --top-module conv_acc_tb -f vlog.f -o conv_acc_sim \
  && ./obj_dir/conv_acc_sim > sim.log 2>&1 || echo "Simulation did not complete" >> sim.log
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
